//--- logic/cart_pkg.sv
// Offsets assume a 512-byte copier header ahead of the ROM image; size exponents above 14 wrap the 24-bit masks
package cart_pkg;

	// ============================================================
	// Widths
	// ============================================================
	typedef logic [15:0]  dl_data_t;
	typedef logic [23:0]  mask_t;
	typedef logic [3:0]   size_code_t;
	typedef logic [7:0]   rom_type_t;
	typedef logic [31:0]  lba_t;
	// Flags, address, compare, replace; most significant first
	typedef logic [127:0] cheat_t;

	// ============================================================
	// Modes and states
	// ============================================================
	typedef enum logic [2:0] {
		hdr_auto      = 3'd0,
		hdr_no_header = 3'd1,
		hdr_lorom     = 3'd2,
		hdr_hirom     = 3'd3,
		hdr_exhirom   = 3'd4
	} header_mode_t;

	typedef enum logic [1:0] {
		region_auto = 2'd0,
		region_ntsc = 2'd1,
		region_pal  = 2'd2
	} region_sel_t;

	typedef enum logic [1:0] {
		bk_idle     = 2'd0,
		bk_request  = 2'd1,
		bk_transfer = 2'd2
	} bk_state_t;

	// ============================================================
	// Header layout and download constants
	// ============================================================
	localparam logic [31:0] COPIER_OFS       = 32'd512;
	// Mapper size word offsets, before the copier header
	localparam logic [31:0] LOROM_SIZE_OFS   = 32'h0000_7FD6;
	localparam logic [31:0] HIROM_SIZE_OFS   = 32'h0000_FFD6;
	localparam logic [31:0] EXHIROM_SIZE_OFS = 32'h0040_FFD6;
	localparam logic [7:0]  CODE_INDEX       = 8'hFF;
	// 512-byte SD blocks
	localparam int unsigned BLOCK_SHIFT      = 9;

endpackage

//--- logic/dl_word_if.sv
// Carries download words one cycle after the host stream; there is no back-pressure
`timescale 1ns/1ps

interface dl_word_if #(
	parameter int DL_ADDR_W = 25
);
	import cart_pkg::*;

	logic [DL_ADDR_W-1:0] addr;
	dl_data_t             data;
	logic                 wr;
	// Index class of the current download
	logic                 is_cart;
	logic                 is_code;
	// One-cycle pulses at the edges of a cartridge download
	logic                 cart_start;
	logic                 cart_end;
	logic                 cart_active;

	modport src (
		output addr, data, wr, is_cart, is_code, cart_start, cart_end, cart_active
	);

	modport sink (
		input addr, data, wr, is_cart, is_code, cart_start, cart_end, cart_active
	);

endinterface

//--- logic/download_decoder.sv
// Every host word is accepted; index 8'hFF is a cheat download and any other index is a cartridge
`timescale 1ns/1ps

module download_decoder #(
	parameter int DL_ADDR_W = 25
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 ioctl_download,
	input  logic [7:0]           ioctl_index,
	input  logic [DL_ADDR_W-1:0] ioctl_addr,
	input  cart_pkg::dl_data_t   ioctl_dout,
	input  logic                 ioctl_wr,
	dl_word_if.src               dl
);
	import cart_pkg::*;

	logic code_index;
	logic cart_dl;
	logic cart_dl_q;

	assign code_index = (ioctl_index == CODE_INDEX);
	assign cart_dl    = ioctl_download & ~code_index;

	// Word payload
	always_ff @(posedge clk_sys) begin
		dl.addr <= ioctl_addr;
		dl.data <= ioctl_dout;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			dl.wr         <= 1'b0;
			dl.is_cart    <= 1'b0;
			dl.is_code    <= 1'b0;
			dl.cart_start <= 1'b0;
			dl.cart_end   <= 1'b0;
			cart_dl_q     <= 1'b0;
		end else begin
			dl.wr         <= ioctl_wr & ioctl_download;
			dl.is_cart    <= ~code_index;
			dl.is_code    <= code_index;
			// Edges of the cartridge download level
			dl.cart_start <= cart_dl & ~cart_dl_q;
			dl.cart_end   <= ~cart_dl & cart_dl_q;
			cart_dl_q     <= cart_dl;
		end
	end

	assign dl.cart_active = cart_dl_q;

endmodule

//--- logic/header_detect.sv
// Sizes come from the copier-offset header; masks follow the size word by two cycles and pal only moves when idle
`timescale 1ns/1ps

module header_detect #(
	parameter int DL_ADDR_W = 25
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	dl_word_if.sink                dl,
	input  cart_pkg::header_mode_t header_mode,
	input  cart_pkg::region_sel_t  region_sel,
	output cart_pkg::rom_type_t    rom_type,
	output cart_pkg::mask_t        rom_mask,
	output cart_pkg::mask_t        ram_mask,
	output logic                   pal
);
	import cart_pkg::*;

	localparam logic [DL_ADDR_W-1:0] LOROM_ADDR   = DL_ADDR_W'(LOROM_SIZE_OFS + COPIER_OFS);
	localparam logic [DL_ADDR_W-1:0] HIROM_ADDR   = DL_ADDR_W'(HIROM_SIZE_OFS + COPIER_OFS);
	localparam logic [DL_ADDR_W-1:0] EXHIROM_ADDR = DL_ADDR_W'(EXHIROM_SIZE_OFS + COPIER_OFS);

	size_code_t           rom_code;
	size_code_t           ram_code;
	size_code_t           rom_code_nxt;
	size_code_t           ram_code_nxt;
	logic                 region;
	logic                 cart_wr;
	logic                 forced;
	logic [DL_ADDR_W-1:0] size_addr;
	logic                 rom_hit;
	logic                 ram_hit;

	assign cart_wr = dl.wr & dl.is_cart;

	// Size word location of the forced mapper mode
	always_comb begin
		forced    = 1'b1;
		size_addr = LOROM_ADDR;
		case (header_mode)
			hdr_lorom:   size_addr = LOROM_ADDR;
			hdr_hirom:   size_addr = HIROM_ADDR;
			hdr_exhirom: size_addr = EXHIROM_ADDR;
			default:     forced = 1'b0;
		endcase
	end

	// RAM size word sits two bytes after the ROM size word
	assign rom_hit = forced && (dl.addr == size_addr);
	assign ram_hit = forced && (dl.addr == size_addr + DL_ADDR_W'(2));

	always_comb begin
		rom_code_nxt = rom_code;
		ram_code_nxt = ram_code;
		if (cart_wr) begin
			if (dl.addr == '0) begin
				rom_code_nxt = 4'hC;
				ram_code_nxt = 4'h0;
				if (header_mode == hdr_auto && dl.data[7:0] != 8'h00) begin
					{ram_code_nxt, rom_code_nxt} = dl.data[7:0];
				end
			end
			if (rom_hit) begin
				rom_code_nxt = dl.data[11:8];
			end
			if (ram_hit) begin
				ram_code_nxt = dl.data[3:0];
			end
		end
	end

	// ============================================================
	// Type and mapper byte
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (cart_wr && dl.addr == '0) begin
			case (header_mode)
				hdr_no_header, hdr_lorom: rom_type <= 8'd0;
				hdr_hirom:                rom_type <= 8'd1;
				hdr_exhirom:              rom_type <= 8'd2;
				default:                  rom_type <= dl.data[15:8];
			endcase
		end
	end

	// ============================================================
	// Size codes, masks and region
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_code <= 4'hC;
			ram_code <= 4'h0;
			rom_mask <= '0;
			ram_mask <= '0;
			region   <= 1'b0;
			pal      <= 1'b0;
		end else begin
			if (cart_wr) begin
				rom_code <= rom_code_nxt;
				ram_code <= ram_code_nxt;
				rom_mask <= (mask_t'(1024) << rom_code_nxt) - mask_t'(1);
				ram_mask <= (ram_code_nxt != 4'h0) ?
					(mask_t'(1024) << ram_code_nxt) - mask_t'(1) : mask_t'(0);
				if (dl.addr == DL_ADDR_W'(2)) begin
					region <= dl.data[8];
				end
			end
			if (!dl.cart_active) begin
				pal <= (region_sel == region_auto) ? region : (region_sel == region_pal);
			end
		end
	end

endmodule

//--- logic/cheat_assembler.sv
// Word offsets wrap every 16 bytes; a code is only complete once the word at offset 14 arrives
`timescale 1ns/1ps

module cheat_assembler (
	input  logic             clk_sys,
	input  logic             reset,
	dl_word_if.sink          dl,
	output cart_pkg::cheat_t cheat_code,
	output logic             cheat_valid,
	output logic             cheat_clear
);
	import cart_pkg::*;

	logic code_wr;
	logic clear_pulse;

	assign code_wr = dl.wr & dl.is_code;

	// Low word of each field first
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (dl.addr[3:0])
				4'd0:  cheat_code[111:96]  <= dl.data;
				4'd2:  cheat_code[127:112] <= dl.data;
				4'd4:  cheat_code[79:64]   <= dl.data;
				4'd6:  cheat_code[95:80]   <= dl.data;
				4'd8:  cheat_code[47:32]   <= dl.data;
				4'd10: cheat_code[63:48]   <= dl.data;
				4'd12: cheat_code[15:0]    <= dl.data;
				4'd14: cheat_code[31:16]   <= dl.data;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cheat_valid <= 1'b0;
			clear_pulse <= 1'b0;
		end else begin
			cheat_valid <= code_wr && (dl.addr[3:0] == 4'd14);
			clear_pulse <= code_wr && (dl.addr[3:0] == 4'd0);
		end
	end

	// A new cartridge wipes every stored code
	assign cheat_clear = clear_pulse | dl.cart_active;

endmodule

//--- logic/backup_sequencer.sv
// One operation at a time; requests during a transfer are dropped and sd_ack must fall before the next block
`timescale 1ns/1ps

module backup_sequencer (
	input  logic            clk_sys,
	input  logic            reset,
	dl_word_if.sink         dl,
	input  cart_pkg::mask_t ram_mask,
	input  logic            bk_load,
	input  logic            bk_save,
	input  logic            img_mounted,
	input  logic            img_readonly,
	input  logic            img_present,
	input  logic            sd_ack,
	output cart_pkg::lba_t  sd_lba,
	output logic            sd_rd,
	output logic            sd_wr,
	output logic            bk_busy,
	output logic            bk_loading,
	output logic            bk_enabled
);
	import cart_pkg::*;

	bk_state_t state;
	logic      load_prev;
	logic      save_prev;
	logic      load_rise;
	logic      save_rise;
	logic      start_go;
	logic      start_read;
	lba_t      last_lba;

	assign load_rise = bk_load & ~load_prev;
	assign save_rise = bk_save & ~save_prev;
	assign last_lba  = lba_t'(ram_mask >> BLOCK_SHIFT);
	assign bk_busy   = (state != bk_idle);

	// Automatic load after a cartridge wins over a menu request
	always_comb begin
		start_go   = 1'b0;
		start_read = 1'b1;
		if (bk_enabled) begin
			if (dl.cart_end && img_present) begin
				start_go = 1'b1;
			end else if (load_rise) begin
				start_go = 1'b1;
			end else if (save_rise) begin
				start_go   = 1'b1;
				start_read = 1'b0;
			end
		end
	end

	// ============================================================
	// Backup RAM enable
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_enabled <= 1'b0;
		end else if (dl.cart_start) begin
			bk_enabled <= 1'b0;
		end else if (dl.cart_active && img_mounted && !img_readonly) begin
			bk_enabled <= (ram_mask != '0);
		end
	end

	// ============================================================
	// Block sequencer
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state      <= bk_idle;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			bk_loading <= 1'b0;
			load_prev  <= 1'b0;
			save_prev  <= 1'b0;
		end else begin
			load_prev <= bk_load;
			save_prev <= bk_save;
			case (state)
				bk_idle: begin
					if (start_go) begin
						state      <= bk_request;
						sd_lba     <= '0;
						sd_rd      <= start_read;
						sd_wr      <= ~start_read;
						bk_loading <= start_read;
					end
				end
				bk_request: begin
					// Request is held until the SD side answers
					if (sd_ack) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= bk_transfer;
					end
				end
				bk_transfer: begin
					if (!sd_ack) begin
						if (sd_lba >= last_lba) begin
							state      <= bk_idle;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + lba_t'(1);
							sd_rd  <= bk_loading;
							sd_wr  <= ~bk_loading;
							state  <= bk_request;
						end
					end
				end
				default: state <= bk_idle;
			endcase
		end
	end

endmodule

//--- logic/cart_loader_top.sv
// Single clock domain on clk_sys; host stream and SD handshake are expected to be synchronous to it
`timescale 1ns/1ps

module cart_loader_top #(
	parameter int DL_ADDR_W = 25
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	// Host download stream
	input  logic                   ioctl_download,
	input  logic [7:0]             ioctl_index,
	input  logic [DL_ADDR_W-1:0]   ioctl_addr,
	input  cart_pkg::dl_data_t     ioctl_dout,
	input  logic                   ioctl_wr,
	// Cartridge header
	input  cart_pkg::header_mode_t header_mode,
	input  cart_pkg::region_sel_t  region_sel,
	output cart_pkg::rom_type_t    rom_type,
	output cart_pkg::mask_t        rom_mask,
	output cart_pkg::mask_t        ram_mask,
	output logic                   pal,
	// Cheat codes
	output cart_pkg::cheat_t       cheat_code,
	output logic                   cheat_valid,
	output logic                   cheat_clear,
	// Backup RAM and SD image
	input  logic                   bk_load,
	input  logic                   bk_save,
	input  logic                   img_mounted,
	input  logic                   img_readonly,
	input  logic                   img_present,
	input  logic                   sd_ack,
	output cart_pkg::lba_t         sd_lba,
	output logic                   sd_rd,
	output logic                   sd_wr,
	output logic                   bk_busy,
	output logic                   bk_loading,
	output logic                   bk_enabled
);

	dl_word_if #(.DL_ADDR_W(DL_ADDR_W)) dl ();

	download_decoder #(.DL_ADDR_W(DL_ADDR_W)) download_decoder_i (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_wr       (ioctl_wr),
		.dl             (dl.src)
	);

	header_detect #(.DL_ADDR_W(DL_ADDR_W)) header_detect_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl.sink),
		.header_mode (header_mode),
		.region_sel  (region_sel),
		.rom_type    (rom_type),
		.rom_mask    (rom_mask),
		.ram_mask    (ram_mask),
		.pal         (pal)
	);

	cheat_assembler cheat_assembler_i (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.dl          (dl.sink),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid),
		.cheat_clear (cheat_clear)
	);

	backup_sequencer backup_sequencer_i (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl           (dl.sink),
		.ram_mask     (ram_mask),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_present  (img_present),
		.sd_ack       (sd_ack),
		.sd_lba       (sd_lba),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading),
		.bk_enabled   (bk_enabled)
	);

endmodule

//--- dv/cart_loader_properties.sv
// Checks only the SD handshake and pulse rules at the top-level ports; data values are left to the testbench
`timescale 1ns/1ps

module cart_loader_properties (
	input logic clk_sys,
	input logic reset,
	input logic sd_rd,
	input logic sd_wr,
	input logic sd_ack,
	input logic cheat_valid,
	input logic bk_busy
);

	int fail_excl = 0;
	int fail_hold = 0;
	int fail_pulse = 0;
	int fail_reset = 0;
	int failures;

	assign failures = fail_excl + fail_hold + fail_pulse + fail_reset;

	// Read and write never requested together
	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (!reset)
		!(sd_rd && sd_wr))
		else begin
			fail_excl = fail_excl + 1;
			$error("sd_rd and sd_wr are high in the same cycle");
		end

	// A request stays up until sd_ack answers
	request_held: assert property (@(posedge clk_sys) disable iff (!reset)
		((sd_rd || sd_wr) && !sd_ack) |=> (sd_rd || sd_wr))
		else begin
			fail_hold = fail_hold + 1;
			$error("SD request dropped before sd_ack");
		end

	cheat_valid_pulse: assert property (@(posedge clk_sys) disable iff (!reset)
		cheat_valid |=> !cheat_valid)
		else begin
			fail_pulse = fail_pulse + 1;
			$error("cheat_valid stayed high for more than one cycle");
		end

	busy_low_after_reset: assert property (@(posedge clk_sys)
		!reset |=> !bk_busy)
		else begin
			fail_reset = fail_reset + 1;
			$error("bk_busy is high right after reset");
		end

endmodule

bind cart_loader_top cart_loader_properties cart_loader_properties_i (
	.clk_sys     (clk_sys),
	.reset       (reset),
	.sd_rd       (sd_rd),
	.sd_wr       (sd_wr),
	.sd_ack      (sd_ack),
	.cheat_valid (cheat_valid),
	.bk_busy     (bk_busy)
);

//--- dv/cart_loader_tb.sv
// Runs one feature at a time from a fixed seed; the SD model answers every request, never errors
`timescale 1ns/1ps

module cart_loader_tb;
	import cart_pkg::*;

	localparam int DL_ADDR_W = 25;
	// Five downloads of about 40 cycles and 16 SD blocks of up to 12 cycles, with wide margin
	localparam int TIMEOUT_CYCLES = 4000;
	localparam logic [31:0] RAND_SEED = 32'h7f83176a;
	// LoROM size words sit behind the 512-byte copier header
	localparam logic [DL_ADDR_W-1:0] LOROM_ROM_ADDR = 25'h0081D6;
	localparam logic [DL_ADDR_W-1:0] LOROM_RAM_ADDR = 25'h0081D8;

	logic                 clk_sys;
	logic                 reset;
	logic                 ioctl_download;
	logic [7:0]           ioctl_index;
	logic [DL_ADDR_W-1:0] ioctl_addr;
	dl_data_t             ioctl_dout;
	logic                 ioctl_wr;
	header_mode_t         header_mode;
	region_sel_t          region_sel;
	rom_type_t            rom_type;
	mask_t                rom_mask;
	mask_t                ram_mask;
	logic                 pal;
	cheat_t               cheat_code;
	logic                 cheat_valid;
	logic                 cheat_clear;
	logic                 bk_load;
	logic                 bk_save;
	logic                 img_mounted;
	logic                 img_readonly;
	logic                 img_present;
	logic                 sd_ack = 1'b0;
	lba_t                 sd_lba;
	logic                 sd_rd;
	logic                 sd_wr;
	logic                 bk_busy;
	logic                 bk_loading;
	logic                 bk_enabled;

	int   value_errors = 0;
	int   cycle_count = 0;
	int   valid_count = 0;
	int   clear_count = 0;
	int   busy_count = 0;
	int   loading_bad = 0;
	logic exp_loading = 1'b0;
	lba_t req_lba_q[$];
	logic req_rd_q[$];

	cart_loader_top #(.DL_ADDR_W(DL_ADDR_W)) cart_loader_top_i (.*);

	initial clk_sys = 1'b0;
	always #2 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
	end

	// ============================================================
	// SD image model and monitors
	// ============================================================
	always begin : sd_model
		int delay;
		@(posedge clk_sys);
		if (reset && (sd_rd || sd_wr) && !sd_ack) begin
			req_lba_q.push_back(sd_lba);
			req_rd_q.push_back(sd_rd);
			// Ack 2 to 5 cycles after the request rose
			delay = 2 + int'($urandom % 4);
			repeat (delay - 1) @(posedge clk_sys);
			sd_ack <= 1'b1;
			repeat (3) @(posedge clk_sys);
			sd_ack <= 1'b0;
		end
	end

	always @(negedge clk_sys) begin
		if (reset) begin
			if (cheat_valid) begin
				valid_count <= valid_count + 1;
			end
			if (cheat_clear && ioctl_index == 8'hFF) begin
				clear_count <= clear_count + 1;
			end
			if (bk_busy) begin
				busy_count <= busy_count + 1;
			end
			if (bk_busy && bk_loading !== exp_loading) begin
				loading_bad <= loading_bad + 1;
			end
		end
	end

	// ============================================================
	// Helpers
	// ============================================================
	// Size is 1 KiB shifted left by the code, RAM code 0 means no RAM
	function automatic mask_t size_mask(input logic [3:0] code, input logic is_ram);
		mask_t m;
		if (is_ram && code == 4'd0) begin
			m = '0;
		end else begin
			m = (mask_t'(1) << (32'(code) + 32'd10)) - mask_t'(1);
		end
		return m;
	endfunction

	task automatic check_equal(input string what, input logic [127:0] got,
			input logic [127:0] exp);
		assert (got === exp) else begin
			value_errors = value_errors + 1;
			$display("FAILED at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic begin_download(input logic [7:0] index);
		@(posedge clk_sys);
		ioctl_index    <= index;
		ioctl_download <= 1'b1;
	endtask

	task automatic write_word(input logic [DL_ADDR_W-1:0] addr, input dl_data_t data);
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr   <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
	endtask

	task automatic end_download();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge clk_sys);
	endtask

	task automatic wait_backup_done();
		while (!bk_busy) @(posedge clk_sys);
		while (bk_busy) @(posedge clk_sys);
	endtask

	task automatic check_blocks(input int base, input logic is_read, input int count);
		check_equal("request count", 128'(req_lba_q.size() - base), 128'(count));
		for (int i = 0; i < count; i++) begin
			check_equal($sformatf("sd_lba of block %0d", i), 128'(req_lba_q[base + i]), 128'(i));
			check_equal($sformatf("read flag of block %0d", i), 128'(req_rd_q[base + i]),
				128'(is_read));
		end
	endtask

	task automatic finish_run(input logic timed_out);
		int assert_fails;
		assert_fails = cart_loader_top_i.cart_loader_properties_i.failures;
		$display("Errors: %0d value mismatches, %0d assertion failures, %0d timeouts",
			value_errors, assert_fails, timed_out);
		if (value_errors == 0 && assert_fails == 0 && !timed_out) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	endtask

	initial begin : watchdog
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("Timeout: the test sequence did not finish within %0d cycles", TIMEOUT_CYCLES);
		finish_run(1'b1);
	end

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin : main
		dl_data_t words [8];
		cheat_t   exp_code;
		int       base;
		int       blocks;
		int       valid_before;
		int       clear_before;
		int       loading_before;
		int       busy_before;
		void'($urandom(RAND_SEED));
		reset          = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		header_mode    = hdr_auto;
		region_sel     = region_auto;
		bk_load        = 1'b0;
		bk_save        = 1'b0;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_present    = 1'b0;
		idle_cycles(4);
		reset <= 1'b1;

		// Auto header, size byte 8'h2A is RAM code 2 and ROM code 10
		begin_download(8'h00);
		write_word(25'd0, 16'h5A2A);
		write_word(25'd2, 16'h0100);
		end_download();
		idle_cycles(3);
		@(negedge clk_sys);
		check_equal("rom_type", 128'(rom_type), 128'(8'h5A));
		check_equal("rom_mask", 128'(rom_mask), 128'(size_mask(4'd10, 1'b0)));
		check_equal("ram_mask", 128'(ram_mask), 128'(size_mask(4'd2, 1'b1)));
		check_equal("pal", 128'(pal), 128'(1'b1));

		// LoROM forced, NTSC selected
		@(posedge clk_sys);
		header_mode <= hdr_lorom;
		region_sel  <= region_ntsc;
		begin_download(8'h00);
		write_word(25'd0, 16'hC355);
		write_word(LOROM_ROM_ADDR, 16'h0900);
		write_word(LOROM_RAM_ADDR, 16'h0000);
		end_download();
		idle_cycles(3);
		@(negedge clk_sys);
		check_equal("rom_type", 128'(rom_type), 128'(8'h00));
		check_equal("rom_mask", 128'(rom_mask), 128'(size_mask(4'd9, 1'b0)));
		check_equal("ram_mask", 128'(ram_mask), 128'(size_mask(4'd0, 1'b1)));
		check_equal("pal", 128'(pal), 128'(1'b0));

		// Cheat code from eight random words
		valid_before = valid_count;
		clear_before = clear_count;
		begin_download(8'hFF);
		for (int i = 0; i < 8; i++) begin
			words[i] = dl_data_t'($urandom);
			write_word(DL_ADDR_W'(2 * i), words[i]);
		end
		end_download();
		idle_cycles(3);
		@(negedge clk_sys);
		exp_code = {words[1], words[0], words[3], words[2],
			words[5], words[4], words[7], words[6]};
		check_equal("cheat_code", cheat_code, exp_code);
		check_equal("cheat_valid pulses", 128'(valid_count - valid_before), 128'(1));
		check_equal("cheat_clear pulses", 128'(clear_count - clear_before), 128'(1));

		// Automatic load after a cart with RAM code 2
		@(posedge clk_sys);
		header_mode <= hdr_auto;
		region_sel  <= region_auto;
		img_present <= 1'b1;
		img_mounted <= 1'b1;
		exp_loading = 1'b1;
		base = req_lba_q.size();
		loading_before = loading_bad;
		blocks = int'(size_mask(4'd2, 1'b1) >> 9) + 1;
		begin_download(8'h00);
		write_word(25'd0, 16'h0129);
		idle_cycles(3);
		// Codes are wiped for as long as a cart is loading
		@(negedge clk_sys);
		check_equal("cheat_clear during cart", 128'(cheat_clear), 128'(1'b1));
		end_download();
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		wait_backup_done();
		@(negedge clk_sys);
		check_blocks(base, 1'b1, blocks);
		check_equal("bk_loading mismatches", 128'(loading_bad - loading_before), 128'(0));

		// Save walks the same blocks as writes
		exp_loading = 1'b0;
		base = req_lba_q.size();
		@(posedge clk_sys);
		bk_save <= 1'b1;
		wait_backup_done();
		bk_save <= 1'b0;
		@(negedge clk_sys);
		check_blocks(base, 1'b0, blocks);
		check_equal("bk_loading mismatches", 128'(loading_bad - loading_before), 128'(0));

		// Cart without backup RAM leaves the sequencer disabled
		@(posedge clk_sys);
		img_mounted <= 1'b1;
		begin_download(8'h00);
		write_word(25'd0, 16'h000A);
		idle_cycles(3);
		end_download();
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		idle_cycles(3);
		@(negedge clk_sys);
		check_equal("bk_enabled", 128'(bk_enabled), 128'(1'b0));
		base = req_lba_q.size();
		busy_before = busy_count;
		@(posedge clk_sys);
		bk_load <= 1'b1;
		idle_cycles(20);
		bk_load <= 1'b0;
		@(negedge clk_sys);
		check_equal("requests while disabled", 128'(req_lba_q.size() - base), 128'(0));
		check_equal("busy cycles while disabled", 128'(busy_count - busy_before), 128'(0));

		finish_run(1'b0);
	end

endmodule

//--- verilog.f
logic/cart_pkg.sv
logic/dl_word_if.sv
logic/download_decoder.sv
logic/header_detect.sv
logic/cheat_assembler.sv
logic/backup_sequencer.sv
logic/cart_loader_top.sv
dv/cart_loader_properties.sv
dv/cart_loader_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f \
	--top-module cart_loader_tb -o cart_loader_sim

./obj_dir/cart_loader_sim +verilator+error+limit+100 | tee sim.log

if grep -qx "Simulation passed" sim.log; then
	exit 0
else
	exit 1
fi
